/* source/nes_bus_pkg.sv */
//*********************************************************************
// Shared widths, address map and bus structs for the NES bus fabric
// NTSC address map only, PRG addresses reach memory untranslated
//*********************************************************************
package nes_bus_pkg;

	typedef logic [15:0] cpu_addr_t;  // 6502 address space
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;  // External memory, 4 MB
	typedef logic [13:0] chr_addr_t;  // PPU VRAM space

	// One CPU bus cycle, also the bus after the DMA override
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      rnw;     // 1 = read
	} cpu_bus_t;

	typedef struct packed {
		chr_addr_t addr;
		byte_t     wdata;
		logic      read;
		logic      write;
	} chr_req_t;

	// Request to the external memory, one latch per reader
	typedef struct packed {
		mem_addr_t addr;
		byte_t     wdata;
		logic      read_cpu;  // Loads the CPU latch
		logic      read_ppu;  // Loads the PPU latch
		logic      write;
	} mem_req_t;

	typedef struct packed {
		logic [2:0] index;  // $2000-$2007 mirror index
		byte_t      wdata;
		logic       read;
		logic       write;
	} ppu_reg_t;

	localparam cpu_addr_t OAM_DMA_ADDR    = 16'h4014;
	localparam cpu_addr_t OAM_DATA_ADDR   = 16'h2004;
	localparam cpu_addr_t APU_STATUS_ADDR = 16'h4015;
	localparam cpu_addr_t JOY1_ADDR       = 16'h4016;
	localparam cpu_addr_t JOY2_ADDR       = 16'h4017;
	localparam cpu_addr_t PPU_BASE        = 16'h2000;
	localparam cpu_addr_t PPU_END         = 16'h4000;  // Exclusive
	localparam cpu_addr_t APU_BASE        = 16'h4000;
	localparam cpu_addr_t APU_END         = 16'h4018;  // Exclusive
	localparam cpu_addr_t OPEN_BUS_END    = 16'h4100;  // Exclusive

endpackage

/* source/clock_divider.sv */
//*********************************************************************
// Master clock divider, CPU_DIV and PPU_DIV must both be at least 2
// Strobes are one clock wide, first ones land a full period after reset
//*********************************************************************
`timescale 1ns/100ps

module clock_divider #(
	parameter int CPU_DIV = 12,  // Master clocks per CPU cycle
	parameter int PPU_DIV = 4    // Master clocks per PPU cycle
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic m2,
	output logic odd_cycle
);

	localparam int CPU_W = $clog2(CPU_DIV);
	localparam int PPU_W = $clog2(PPU_DIV);
	localparam logic [CPU_W-1:0] CPU_LAST = CPU_W'(CPU_DIV - 1);
	localparam logic [CPU_W-1:0] M2_START = CPU_W'(CPU_DIV / 2 - 1);  // 7 of 12 clocks by default
	localparam logic [PPU_W-1:0] PPU_LAST = PPU_W'(PPU_DIV - 1);

	logic [CPU_W-1:0] cpu_cnt;
	logic [PPU_W-1:0] ppu_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt   <= '0;
			ppu_cnt   <= '0;
			odd_cycle <= 1'b0;
		end else begin
			cpu_cnt <= cpu_ce ? '0 : cpu_cnt + 1'b1;  // Wraps on the strobe
			ppu_cnt <= ppu_ce ? '0 : ppu_cnt + 1'b1;
			if (cpu_ce)
				odd_cycle <= ~odd_cycle;  // Even/odd for DMA alignment
		end
	end

	assign cpu_ce = (cpu_cnt == CPU_LAST);
	assign ppu_ce = (ppu_cnt == PPU_LAST);
	assign m2     = (cpu_cnt >= M2_START);  // Runs to the end of the CPU cycle

endmodule

/* source/dma_controller.sv */
//*********************************************************************
// Sprite OAM DMA and DMC sample DMA, stepped once per CPU cycle
// The paused CPU must hold a read cycle or the sprite DMA never aligns
// Sprite reads land on even cycles, $2004 writes on odd cycles
//*********************************************************************
`timescale 1ns/100ps

module dma_controller (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  odd_cycle,
	input  nes_bus_pkg::cpu_bus_t cpu_bus,        // Raw CPU cycle, before the override
	input  logic                  dmc_request,
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	input  nes_bus_pkg::byte_t    data_from_ram,
	output logic                  dma_enable,
	output nes_bus_pkg::cpu_bus_t dma_bus,
	output logic                  dmc_ack,
	output logic                  pause_cpu
);
	import nes_bus_pkg::*;

	// Bit 0 holds the CPU, bit 1 owns the bus
	localparam logic [1:0] SPR_IDLE  = 2'b00;
	localparam logic [1:0] SPR_ALIGN = 2'b01;
	localparam logic [1:0] SPR_RUN   = 2'b11;

	logic       dmc_state;  // DMC fetch pending or in progress
	logic [1:0] spr_state;
	cpu_addr_t  spr_addr;   // Source page and byte index
	byte_t      spr_data;   // Byte on its way to $2004
	logic [8:0] next_low;   // Carry out ends the transfer
	logic       sprite_trigger;

	assign sprite_trigger = (cpu_bus.addr == OAM_DMA_ADDR) && !cpu_bus.rnw &&
		(spr_state == SPR_IDLE);
	assign next_low = {1'b0, spr_addr[7:0]} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= SPR_IDLE;
			spr_addr  <= '0;
		end else if (cpu_ce) begin
			// DMC grabs an even cycle, only while the CPU reads
			if (!dmc_state)
				dmc_state <= dmc_request && cpu_bus.rnw && !odd_cycle;
			else if (!odd_cycle)
				dmc_state <= 1'b0;  // Fetch done this cycle

			if (sprite_trigger) begin
				spr_addr  <= {cpu_bus.wdata, 8'h00};
				spr_state <= SPR_ALIGN;
			end else if (spr_state == SPR_ALIGN) begin
				if (cpu_bus.rnw && odd_cycle)
					spr_state <= SPR_RUN;  // Next cycle is an even read
			end else if (spr_state == SPR_RUN) begin
				if (!odd_cycle) begin
					if (dmc_ack)
						spr_state <= SPR_ALIGN;  // Stolen read, redo it after realigning
				end else begin
					spr_addr[7:0] <= next_low[7:0];
					if (next_low[8])
						spr_state <= SPR_IDLE;  // 256th write done
				end
			end
		end
	end

	// Byte fetched on the even cycle
	always_ff @(posedge clk) begin
		if (cpu_ce && spr_state[1] && !odd_cycle)
			spr_data <= data_from_ram;
	end

	assign dmc_ack    = dmc_state && !odd_cycle;
	assign dma_enable = dmc_ack || spr_state[1];
	assign pause_cpu  = spr_state[0] || dmc_request;

	always_comb begin
		if (dmc_ack)
			dma_bus.addr = dmc_addr;
		else if (odd_cycle)
			dma_bus.addr = OAM_DATA_ADDR;
		else
			dma_bus.addr = spr_addr;
		dma_bus.wdata = spr_data;
		dma_bus.rnw   = !odd_cycle;  // Read even, write odd
	end

endmodule

/* source/bus_decoder.sv */
//*********************************************************************
// CPU address decode, register strobes and read data mux
// All strobes are qualified by m2, PRG accesses go out untranslated
// $4018-$40FF and unmapped APU registers read back the open bus value
//*********************************************************************
`timescale 1ns/100ps

module bus_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  m2,
	input  nes_bus_pkg::cpu_bus_t bus,
	input  nes_bus_pkg::byte_t    ppu_rdata,
	input  nes_bus_pkg::byte_t    apu_status,
	input  nes_bus_pkg::byte_t    mem_rdata_cpu,
	input  logic [3:0]            joypad_data,  // Pads 0-1 plus power pad
	input  logic                  mic,
	output nes_bus_pkg::ppu_reg_t ppu_reg,
	output logic                  joypad_strobe,
	output logic [1:0]            joypad_clock,
	output logic                  prg_read,
	output logic                  prg_write,
	output nes_bus_pkg::byte_t    cpu_rdata
);
	import nes_bus_pkg::*;

	logic  ppu_cs;
	logic  apu_cs;
	logic  open_cs;
	logic  prg_cs;
	logic  joy1_cs;
	logic  joy2_cs;
	logic  rd;
	logic  wr;
	byte_t open_bus;  // Last value seen on the data bus

	assign ppu_cs  = (bus.addr >= PPU_BASE) && (bus.addr < PPU_END);
	assign apu_cs  = (bus.addr >= APU_BASE) && (bus.addr < APU_END);
	assign open_cs = (bus.addr >= APU_END) && (bus.addr < OPEN_BUS_END);
	assign prg_cs  = !ppu_cs && !apu_cs && !open_cs;  // RAM and cartridge
	assign joy1_cs = (bus.addr == JOY1_ADDR);
	assign joy2_cs = (bus.addr == JOY2_ADDR);

	assign rd = bus.rnw && m2;
	assign wr = !bus.rnw && m2;

	assign ppu_reg.index = bus.addr[2:0];
	assign ppu_reg.wdata = bus.wdata;
	assign ppu_reg.read  = ppu_cs && rd;
	assign ppu_reg.write = ppu_cs && wr;

	assign joypad_strobe = joy1_cs && wr && bus.wdata[0];  // Latch pads while high
	assign joypad_clock  = {joy2_cs && rd, joy1_cs && rd};

	assign prg_read  = prg_cs && rd;
	assign prg_write = prg_cs && wr;

	// Data bus capacitance, held one clock
	always_ff @(posedge clk) begin
		open_bus <= cpu_rdata;
	end

	always_comb begin
		if (reset)
			cpu_rdata = '0;
		else if (joy1_cs)
			cpu_rdata = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		else if (joy2_cs)
			cpu_rdata = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		else if (apu_cs)
			cpu_rdata = (bus.addr == APU_STATUS_ADDR) ? apu_status : open_bus;  // Write-only regs
		else if (open_cs)
			cpu_rdata = open_bus;
		else if (ppu_cs)
			cpu_rdata = ppu_rdata;
		else
			cpu_rdata = mem_rdata_cpu;  // CPU latch of the memory
	end

endmodule

/* source/memory_multiplex.sv */
//*********************************************************************
// One external memory shared by CHR and PRG, CHR always wins the clock
// A blocked PRG access is replayed on the next PPU cycle without CHR
// PRG is served within two PPU cycles unless CHR holds two in a row
//*********************************************************************
`timescale 1ns/100ps

module memory_multiplex (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ppu_ce,
	input  logic                  prg_read,
	input  logic                  prg_write,
	input  nes_bus_pkg::cpu_bus_t bus,
	input  nes_bus_pkg::chr_req_t chr_req,
	output nes_bus_pkg::mem_req_t mem_req
);
	import nes_bus_pkg::*;

	logic chr_busy;
	logic saved_read;   // PRG read that lost to CHR
	logic saved_write;  // PRG write that lost to CHR

	assign chr_busy = chr_req.read || chr_req.write;

	always_ff @(posedge clk) begin
		if (reset) begin
			saved_read  <= 1'b0;
			saved_write <= 1'b0;
		end else if (ppu_ce) begin
			if (chr_busy) begin
				saved_read  <= prg_read || saved_read;  // Keep until a free slot
				saved_write <= prg_write || saved_write;
			end else begin
				saved_read  <= 1'b0;  // Replayed during this PPU cycle
				saved_write <= 1'b0;
			end
		end
	end

	always_comb begin
		mem_req.addr     = chr_busy ? mem_addr_t'(chr_req.addr) : mem_addr_t'(bus.addr);
		mem_req.wdata    = chr_req.write ? chr_req.wdata : bus.wdata;
		mem_req.read_ppu = chr_req.read;
		mem_req.read_cpu = !chr_busy && (prg_read || saved_read);
		mem_req.write    = chr_busy ? chr_req.write : (prg_write || saved_write);
	end

endmodule

/* source/nes_bus_top.sv */
//*********************************************************************
// NES bus and DMA fabric, CPU, PPU, APU and mapper sit outside
// The CPU must change its bus only after cpu_ce and hold it while paused
//*********************************************************************
`timescale 1ns/100ps

module nes_bus_top #(
	parameter int CPU_DIV = 12,  // 16 for PAL-like division
	parameter int PPU_DIV = 4    // 5 for PAL-like division
) (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_bus_pkg::cpu_bus_t  cpu_bus,
	input  logic                   dmc_request,
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	input  nes_bus_pkg::chr_req_t  chr_req,
	input  nes_bus_pkg::byte_t     mem_rdata_cpu,
	input  nes_bus_pkg::byte_t     ppu_rdata,
	input  nes_bus_pkg::byte_t     apu_status,
	input  logic [3:0]             joypad_data,
	input  logic                   mic,
	output logic                   cpu_ce,
	output logic                   ppu_ce,
	output logic                   pause_cpu,
	output logic                   dmc_ack,
	output nes_bus_pkg::byte_t     cpu_rdata,
	output nes_bus_pkg::mem_req_t  mem_req,
	output nes_bus_pkg::ppu_reg_t  ppu_reg,
	output logic                   joypad_strobe,
	output logic [1:0]             joypad_clock
);
	import nes_bus_pkg::*;

	logic     m2;
	logic     odd_cycle;
	logic     dma_enable;
	cpu_bus_t dma_bus;
	cpu_bus_t bus;        // Bus after the DMA override
	logic     prg_read;
	logic     prg_write;

	clock_divider #(
		.CPU_DIV(CPU_DIV),
		.PPU_DIV(PPU_DIV)
	) divider (
		.clk      (clk),
		.reset    (reset),
		.cpu_ce   (cpu_ce),
		.ppu_ce   (ppu_ce),
		.m2       (m2),
		.odd_cycle(odd_cycle)
	);

	dma_controller dma (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.odd_cycle    (odd_cycle),
		.cpu_bus      (cpu_bus),
		.dmc_request  (dmc_request),
		.dmc_addr     (dmc_addr),
		.data_from_ram(cpu_rdata),   // Whatever the bus returned
		.dma_enable   (dma_enable),
		.dma_bus      (dma_bus),
		.dmc_ack      (dmc_ack),
		.pause_cpu    (pause_cpu)
	);

	assign bus = dma_enable ? dma_bus : cpu_bus;  // DMA owns the bus when enabled

	bus_decoder decoder (
		.clk          (clk),
		.reset        (reset),
		.m2           (m2),
		.bus          (bus),
		.ppu_rdata    (ppu_rdata),
		.apu_status   (apu_status),
		.mem_rdata_cpu(mem_rdata_cpu),
		.joypad_data  (joypad_data),
		.mic          (mic),
		.ppu_reg      (ppu_reg),
		.joypad_strobe(joypad_strobe),
		.joypad_clock (joypad_clock),
		.prg_read     (prg_read),
		.prg_write    (prg_write),
		.cpu_rdata    (cpu_rdata)
	);

	memory_multiplex mem_mux (
		.clk      (clk),
		.reset    (reset),
		.ppu_ce   (ppu_ce),
		.prg_read (prg_read),
		.prg_write(prg_write),
		.bus      (bus),
		.chr_req  (chr_req),
		.mem_req  (mem_req)
	);

endmodule

/* verification/nes_bus_checker.sv */
//*********************************************************************
// Watches nes_bus_top and compares against reference models
// Bus cycles are checked on cpu_ce, CHR priority on every clock
//*********************************************************************
`timescale 1ns/100ps

module nes_bus_checker #(
	parameter int CPU_DIV = 12,
	parameter int PPU_DIV = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  logic                   ppu_ce,
	input  logic                   pause_cpu,
	input  logic                   dmc_request,
	input  logic                   dmc_ack,
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	input  nes_bus_pkg::cpu_bus_t  cpu_bus,
	input  nes_bus_pkg::chr_req_t  chr_req,
	input  nes_bus_pkg::mem_req_t  mem_req,
	input  nes_bus_pkg::ppu_reg_t  ppu_reg,
	input  nes_bus_pkg::byte_t     cpu_rdata,
	input  logic                   joypad_strobe,
	input  logic [1:0]             joypad_clock,
	input  logic [3:0]             joypad_data,
	input  logic                   mic,
	output int                     check_count,
	output int                     error_count
);
	import nes_bus_pkg::*;

	int    clocks;        // Clocks since reset fell
	int    spr_count;     // $2004 writes seen in this DMA
	int    dmc_requests;
	int    dmc_acks;
	logic  spr_active;
	logic  prev_pause;
	logic  prev_request;
	logic  last_known;    // last_read is a modeled value
	byte_t last_read;
	byte_t spr_page;
	byte_t expected;

	function automatic byte_t ref_mem_value(input mem_addr_t addr);
		return (addr[7:0] ^ addr[15:8]) + 8'd3;
	endfunction

	function automatic logic read_is_modeled(input cpu_addr_t addr, input logic known);
		if (addr < PPU_BASE || addr >= OPEN_BUS_END)
			return 1'b1;  // PRG, straight from memory
		return known && (addr == JOY1_ADDR || addr == JOY2_ADDR || addr >= APU_END);
	endfunction

	// Expected CPU read data, prev is the previous read on the bus
	function automatic byte_t expected_read(input cpu_addr_t addr, input byte_t prev);
		if (addr == JOY1_ADDR)
			return {prev[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		if (addr == JOY2_ADDR)
			return {prev[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		if (addr >= APU_END && addr < OPEN_BUS_END)
			return prev;
		return ref_mem_value(mem_addr_t'(addr));
	endfunction

	task automatic compare(input string name, input int exp_value, input int act_value);
		check_count++;
		if (exp_value != act_value) begin
			error_count++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp_value, act_value);
		end
	endtask

	// Everything that ends with a CPU cycle
	task automatic check_cpu_cycle();
		if (!pause_cpu && !cpu_bus.rnw && cpu_bus.addr == OAM_DMA_ADDR) begin
			spr_active   = 1'b1;
			spr_page     = cpu_bus.wdata;
			spr_count    = 0;
			dmc_requests = 0;
			dmc_acks     = 0;
		end
		if (spr_active && ppu_reg.write) begin
			compare("sprite index", 4, int'(ppu_reg.index));
			compare("sprite data", ref_mem_value(mem_addr_t'({spr_page, spr_count[7:0]})),
				ppu_reg.wdata);
			spr_count++;
		end
		if (dmc_request && !prev_request)
			dmc_requests++;
		if (dmc_ack) begin
			dmc_acks++;
			compare("dmc read strobe", 1, int'(mem_req.read_cpu));
			compare("dmc address", int'(dmc_addr), int'(mem_req.addr));
			compare("dmc data", ref_mem_value(mem_addr_t'(dmc_addr)), cpu_rdata);
		end
		if (prev_pause && !pause_cpu && spr_active) begin
			compare("sprite write count", 256, spr_count);
			compare("dmc ack count", dmc_requests, dmc_acks);
			spr_active = 1'b0;
		end
		if (!pause_cpu)  // Pad shift clocks follow CPU reads of $4016 and $4017
			compare("joypad clock", int'({cpu_bus.rnw && cpu_bus.addr == JOY2_ADDR,
				cpu_bus.rnw && cpu_bus.addr == JOY1_ADDR}), int'(joypad_clock));
		if (pause_cpu)
			last_known = 1'b0;  // DMA cycles drive the data bus
		else if (cpu_bus.rnw && read_is_modeled(cpu_bus.addr, last_known)) begin
			expected = expected_read(cpu_bus.addr, last_read);
			compare("cpu read", expected, cpu_rdata);
			last_read  = expected;
			last_known = 1'b1;
		end else begin
			last_known = 1'b0;
			if (!cpu_bus.rnw && cpu_bus.addr == JOY1_ADDR)
				compare("joypad strobe", int'(cpu_bus.wdata[0]), int'(joypad_strobe));
		end
		prev_pause   = pause_cpu;
		prev_request = dmc_request;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			clocks       = 0;
			check_count  = 0;
			error_count  = 0;
			spr_active   = 1'b0;
			prev_pause   = 1'b0;
			prev_request = 1'b0;
			last_known   = 1'b0;
			last_read    = '0;
		end else begin
			clocks++;
			compare("cpu_ce timing", int'(clocks % CPU_DIV == 0), int'(cpu_ce));
			compare("ppu_ce timing", int'(clocks % PPU_DIV == 0), int'(ppu_ce));
			if (chr_req.read || chr_req.write) begin  // CHR owns the memory
				compare("chr address", int'(chr_req.addr), int'(mem_req.addr));
				compare("chr read_ppu", int'(chr_req.read), int'(mem_req.read_ppu));
				compare("chr write", int'(chr_req.write), int'(mem_req.write));
				compare("chr blocks read_cpu", 0, int'(mem_req.read_cpu));
				if (chr_req.write)
					compare("chr wdata", int'(chr_req.wdata), int'(mem_req.wdata));
			end
			if (cpu_ce)
				check_cpu_cycle();
		end
	end

endmodule

/* verification/nes_bus_tb.sv */
//*********************************************************************
// Testbench for nes_bus_top, plays the CPU, DMC source, CHR port, memory
// CHR traffic never fills two PPU cycles in a row, so PRG reads finish
//*********************************************************************
`timescale 1ns/100ps

module nes_bus_tb;
	import nes_bus_pkg::*;

	localparam int CPU_DIV    = 12;
	localparam int PPU_DIV    = 4;
	localparam int WAIT_LIMIT = 20000;  // Clocks, a DMA with steals needs about 6300

	logic       clk;
	logic       reset;
	cpu_bus_t   cpu_bus;
	logic       dmc_request;
	cpu_addr_t  dmc_addr;
	chr_req_t   chr_req;
	byte_t      mem_rdata_cpu;
	byte_t      ppu_rdata;
	byte_t      apu_status;
	logic [3:0] joypad_data;
	logic       mic;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       pause_cpu;
	logic       dmc_ack;
	byte_t      cpu_rdata;
	mem_req_t   mem_req;
	ppu_reg_t   ppu_reg;
	logic       joypad_strobe;
	logic [1:0] joypad_clock;
	int         check_count;
	int         error_count;
	integer     seed;
	int         chr_rand;
	int         r;
	logic       chr_enable;  // Background CHR traffic on/off

	nes_bus_top #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) DUT (.*);

	nes_bus_checker #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) scoreboard (.*);

	always #20 clk = ~clk;

	// Memory contents follow the address, low byte XOR high byte plus 3
	function automatic byte_t memory_byte(input mem_addr_t addr);
		return (addr[7:0] ^ addr[15:8]) + 8'd3;
	endfunction

	always @(posedge clk) begin
		if (mem_req.read_cpu)
			mem_rdata_cpu <= #1 memory_byte(mem_req.addr);  // CPU latch, one clock later
	end

	// PPU CHR port, a random access at most every other PPU cycle
	always @(posedge clk) begin
		if (ppu_ce) begin
			#1;
			chr_rand = $random(seed);
			if (chr_enable && !chr_req.read && !chr_req.write && chr_rand[0]) begin
				chr_req.addr  = chr_addr_t'(chr_rand[21:8]);
				chr_req.wdata = byte_t'(chr_rand[29:22]);
				chr_req.read  = chr_rand[1];
				chr_req.write = !chr_rand[1];
			end else
				chr_req = '0;
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("TESTS FAILED");
		$finish;
	endtask

	// One CPU bus cycle, held while paused, ends on a cpu_ce with pause low
	task automatic cpu_cycle(input cpu_addr_t addr, input byte_t wdata, input logic rnw);
		int waited;
		waited = 0;
		cpu_bus.addr  = addr;
		cpu_bus.wdata = wdata;
		cpu_bus.rnw   = rnw;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				stop_on_timeout("CPU bus cycle never completed");
		end while (!(cpu_ce && !pause_cpu));
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cpu_cycles(input int count);
		int seen;
		int waited;
		seen = 0;
		waited = 0;
		while (seen < count) begin
			@(negedge clk);
			if (cpu_ce)
				seen++;
			waited++;
			if (waited > WAIT_LIMIT)
				stop_on_timeout("cpu_ce stopped pulsing");
		end
		@(posedge clk);
		#1;
	endtask

	// DMC source, request held until the cycle after dmc_ack
	task automatic run_dmc(input int delay_cycles, input cpu_addr_t addr);
		int waited;
		waited = 0;
		wait_cpu_cycles(delay_cycles);
		dmc_addr    = addr;
		dmc_request = 1'b1;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				stop_on_timeout("dmc_ack never came");
		end while (!(cpu_ce && dmc_ack));
		@(posedge clk);
		#1 dmc_request = 1'b0;
	endtask

	task automatic sprite_dma(input byte_t page, input logic with_dmc);
		int pick;
		pick = $random(seed);
		cpu_cycle(OAM_DMA_ADDR, page, 1'b0);
		if (with_dmc)
			fork
				cpu_cycle(16'h8000 | cpu_addr_t'(pick[11:0]), 8'h00, 1'b1);  // Held read
				run_dmc(20 + int'(pick[19:12]), 16'hC000 | cpu_addr_t'(pick[31:20]));
			join
		else
			cpu_cycle(16'h8000 | cpu_addr_t'(pick[11:0]), 8'h00, 1'b1);
	endtask

	initial begin
		seed          = 76777;
		clk           = 1'b0;
		reset         = 1'b1;
		cpu_bus       = '{addr: 16'h8000, wdata: 8'h00, rnw: 1'b1};
		dmc_request   = 1'b0;
		dmc_addr      = '0;
		chr_req       = '0;
		chr_enable    = 1'b0;
		mem_rdata_cpu = '0;
		ppu_rdata     = 8'h00;
		apu_status    = 8'h00;
		r             = $random(seed);
		joypad_data   = r[3:0];
		mic           = r[4];
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		// Read mux, open bus and joypads
		cpu_cycle(16'h8123, 8'h00, 1'b1);
		cpu_cycle(JOY1_ADDR, 8'h00, 1'b1);
		cpu_cycle(16'h0456, 8'h00, 1'b1);
		cpu_cycle(JOY2_ADDR, 8'h00, 1'b1);
		cpu_cycle(16'h4018, 8'h00, 1'b1);
		cpu_cycle(16'h40FF, 8'h00, 1'b1);
		cpu_cycle(JOY1_ADDR, 8'h01, 1'b0);
		cpu_cycle(JOY1_ADDR, 8'h00, 1'b0);

		// Sprite DMA from random high pages, two with a DMC steal
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			sprite_dma(8'h80 | byte_t'(r[6:0]), i != 0);
		end

		// PRG reads against CHR traffic
		chr_enable = 1'b1;
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			if (r[0])
				cpu_cycle(16'h8000 | cpu_addr_t'(r[15:1]), 8'h00, 1'b1);
			else
				cpu_cycle(cpu_addr_t'(r[13:1]), 8'h00, 1'b1);  // Internal RAM range
		end
		chr_enable = 1'b0;
		cpu_cycle(16'h8000, 8'h00, 1'b1);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* list.f */
source/nes_bus_pkg.sv
source/clock_divider.sv
source/dma_controller.sv
source/bus_decoder.sv
source/memory_multiplex.sv
source/nes_bus_top.sv
verification/nes_bus_checker.sv
verification/nes_bus_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the NES bus fabric simulation with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module nes_bus_tb -f list.f -o nes_bus_sim \
	&& ./obj_dir/nes_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
